/* all.f */
+incdir+include
src/conv_pkg.sv
src/fp_mul.sv
src/fp_add.sv
src/conv_tap_mult.sv
src/conv_add_tree.sv
src/conv_fp_top.sv
dv/conv_fp_chk.sv
dv/conv_fp_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = conv_fp_tb
FLIST = all.f
OBJ   = obj_dir
PASS  = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

# the run passes only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS)$$"

clean:
	rm -rf $(OBJ)

/* dv/conv_fp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_fp_tb import conv_pkg::*; ();

    localparam int clk_per  = 40;
    localparam int n_rand   = 40;
    localparam int n_edge   = 12;
    localparam int n_stream = 60;
    localparam int n_vec    = 3 * n_rand + n_edge + 6 + 2 * n_stream;
    // stream gaps are at most 3 idle cycles per vector
    localparam int wd_cycles = 16 + 4 * n_vec + `CONV_LAT + 200;

    logic                         clk_i = 1'b0;
    logic                         rst_i;
    fp_word_t   [`CONV_TAPS-1:0]  window_i;
    kern_word_u [`CONV_TAPS-1:0]  kernel_i;
    logic       [`CONV_TAPS-1:0]  kern_short_i;
    logic       [`CONV_COORD_W-1:0] row_i;
    logic       [`CONV_COORD_W-1:0] col_i;
    logic                         valid_i;
    fp_word_t                     data_o;
    logic       [`CONV_COORD_W-1:0] row_o;
    logic       [`CONV_COORD_W-1:0] col_o;
    logic                         valid_o;

    int    seed = 27;
    string test_name;

    // expected results in issue order
    fp_word_t                 exp_data_q [$];
    logic [`CONV_COORD_W-1:0] exp_row_q  [$];
    logic [`CONV_COORD_W-1:0] exp_col_q  [$];
    string                    exp_name_q [$];

    always #(clk_per / 2) clk_i = ~clk_i;

    conv_fp_top conv_fp_top_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .window_i     (window_i),
        .kernel_i     (kernel_i),
        .kern_short_i (kern_short_i),
        .row_i        (row_i),
        .col_i        (col_i),
        .valid_i      (valid_i),
        .data_o       (data_o),
        .row_o        (row_o),
        .col_o        (col_o),
        .valid_o      (valid_o)
    );

    //////////////////////////////////////////////////
    // reference model

    // underflow to +0, saturate above exponent 30
    function automatic fp_word_t limit_fp(logic s, int e, logic [`CONV_FRAC_W-1:0] f);
        fp_word_t r;
        r = '0;
        if (e > 30) begin
            r.sign = s;
            r.exp  = 5'd30;
            r.frac = '1;
        end else if (e > 0) begin
            r.sign = s;
            r.exp  = 5'(e);
            r.frac = f;
        end
        return r;
    endfunction

    function automatic fp_word_t model_mul(fp_word_t a, fp_word_t b);
        logic [21:0] p;
        if ((a.exp == '0) || (b.exp == '0)) begin
            return '0;
        end
        p = 22'({1'b1, a.frac}) * 22'({1'b1, b.frac});
        // significand product in [1,4)
        if (p[21]) begin
            return limit_fp(a.sign ^ b.sign, int'(a.exp) + int'(b.exp) - `CONV_BIAS + 1,
                            p[20:11]);
        end
        return limit_fp(a.sign ^ b.sign, int'(a.exp) + int'(b.exp) - `CONV_BIAS, p[19:10]);
    endfunction

    // opt view, zero or signed power of two
    function automatic fp_word_t model_scale(fp_word_t a, kern_word_u k);
        if ((k.opt.cls == cls_zero) || (a.exp == '0)) begin
            return '0;
        end
        return limit_fp(a.sign ^ (k.opt.cls == cls_neg_pow2),
                        int'(a.exp) + int'(k.opt.shift), a.frac);
    endfunction

    function automatic fp_word_t model_add(fp_word_t a, fp_word_t b);
        fp_word_t    hi;
        fp_word_t    lo;
        logic [11:0] sum;
        int          msb;
        if ((a.exp == '0) && (b.exp == '0)) begin
            return '0;
        end
        if (a.exp == '0) begin
            return b;
        end
        if (b.exp == '0) begin
            return a;
        end
        if ({a.exp, a.frac} >= {b.exp, b.frac}) begin
            hi = a;
            lo = b;
        end else begin
            hi = b;
            lo = a;
        end
        // align smaller operand, shifted out bits lost
        sum = {2'b01, lo.frac} >> (hi.exp - lo.exp);
        if (hi.sign == lo.sign) begin
            sum = {2'b01, hi.frac} + sum;
        end else begin
            sum = {2'b01, hi.frac} - sum;
        end
        if (sum == '0) begin
            return '0;
        end
        if (sum[11]) begin
            return limit_fp(hi.sign, int'(hi.exp) + 1, sum[10:1]);
        end
        msb = 0;
        for (int i = 0; i < 11; i++) begin
            if (sum[i]) begin
                msb = i;
            end
        end
        sum = sum << (10 - msb);
        return limit_fp(hi.sign, int'(hi.exp) - (10 - msb), sum[9:0]);
    endfunction

    // nine taps, padded to sixteen, pairs summed in index order
    function automatic fp_word_t ref_conv(fp_word_t [`CONV_TAPS-1:0] w,
                                          kern_word_u [`CONV_TAPS-1:0] k,
                                          logic [`CONV_TAPS-1:0] sh);
        fp_word_t node [`CONV_TREE_IN];
        int       n;
        for (int t = 0; t < `CONV_TREE_IN; t++) begin
            node[t] = '0;
        end
        for (int t = 0; t < `CONV_TAPS; t++) begin
            node[t] = sh[t] ? model_scale(w[t], k[t]) : model_mul(w[t], k[t].fp);
        end
        n = `CONV_TREE_IN;
        while (n > 1) begin
            n = n / 2;
            for (int i = 0; i < n; i++) begin
                node[i] = model_add(node[2*i], node[2*i+1]);
            end
        end
        return node[0];
    endfunction

    //////////////////////////////////////////////////
    // random stimulus

    function automatic int rand_int(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic fp_word_t rand_fp(int lo, int hi);
        fp_word_t r;
        r.sign = (rand_int(2) == 1);
        r.exp  = 5'(lo + rand_int(hi - lo + 1));
        r.frac = 10'(rand_int(1024));
        return r;
    endfunction

    // subnormal or tiny, else near the top of the range
    function automatic fp_word_t rand_extreme();
        return (rand_int(2) == 1) ? rand_fp(0, 2) : rand_fp(29, 31);
    endfunction

    function automatic kern_word_u rand_opt();
        kern_word_u k;
        k.opt.cls   = tap_cls_e'(2'(rand_int(3)));
        k.opt.rsvd  = '0;
        k.opt.shift = 5'(rand_int(13) - 6);
        return k;
    endfunction

    // mode 0 full, 1 shortcut, 2 mixed, 3 extreme, 4 cancel, 5 saturate
    task automatic gen_vec(int mode);
        fp_word_t   [`CONV_TAPS-1:0] w;
        kern_word_u [`CONV_TAPS-1:0] k;
        logic       [`CONV_TAPS-1:0] sh;
        logic [`CONV_COORD_W-1:0]    row;
        logic [`CONV_COORD_W-1:0]    col;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            w[t]  = (mode == 3) ? rand_extreme() : rand_fp(8, 22);
            sh[t] = (mode == 1) || ((mode == 2) && (rand_int(2) == 1));
            if (sh[t]) begin
                k[t] = rand_opt();
            end else begin
                k[t].fp = (mode == 3) ? rand_extreme() : rand_fp(8, 22);
            end
        end
        if (mode == 4) begin
            // tap 1 is the negated twin of tap 0, rest read as zero
            w[1]      = w[0];
            w[1].sign = ~w[0].sign;
            k[1]      = k[0];
            for (int t = 2; t < `CONV_TAPS; t++) begin
                w[t].exp = '0;
            end
        end
        if (mode == 5) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                w[t].exp     = 5'd31;
                w[t].sign    = w[0].sign;
                k[t].fp.exp  = 5'd30;
                k[t].fp.sign = 1'b0;
            end
        end
        row = 16'(rand_int(65536));
        col = 16'(rand_int(65536));
        @(posedge clk_i);
        window_i     <= w;
        kernel_i     <= k;
        kern_short_i <= sh;
        row_i        <= row;
        col_i        <= col;
        valid_i      <= 1'b1;
        exp_data_q.push_back(ref_conv(w, k, sh));
        exp_row_q.push_back(row);
        exp_col_q.push_back(col);
        exp_name_q.push_back(test_name);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk_i);
            valid_i <= 1'b0;
        end
    endtask

    task automatic reset_dut(int n);
        @(posedge clk_i);
        rst_i   <= 1'b1;
        valid_i <= 1'b0;
        repeat (n) @(posedge clk_i);
        rst_i <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // compare

    task automatic compare_fp(string name, fp_word_t exp_v, fp_word_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s data expected %h actual %h", name, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic compare_coord(string name, string field,
                                 logic [`CONV_COORD_W-1:0] exp_v,
                                 logic [`CONV_COORD_W-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s expected %h actual %h", name, field, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "tag mismatch");
        end
    endtask

    // reset drops everything still in flight
    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_data_q.delete();
            exp_row_q.delete();
            exp_col_q.delete();
            exp_name_q.delete();
        end else if (valid_o) begin
            if (exp_data_q.size() == 0) begin
                $display("valid_o came with no result outstanding");
                $display("sim failed");
                $fatal(1, "unexpected output");
            end else begin
                compare_fp(exp_name_q[0], exp_data_q.pop_front(), data_o);
                compare_coord(exp_name_q[0], "row", exp_row_q.pop_front(), row_o);
                compare_coord(exp_name_q[0], "col", exp_col_q.pop_front(), col_o);
                void'(exp_name_q.pop_front());
            end
        end
    end

    initial begin
        #(wd_cycles * clk_per);
        $display("watchdog expired before all results came back");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        rst_i        = 1'b1;
        window_i     = '0;
        kernel_i     = '0;
        kern_short_i = '0;
        row_i        = '0;
        col_i        = '0;
        valid_i      = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;

        test_name = "full_mult";
        repeat (n_rand) gen_vec(0);
        test_name = "shortcut";
        repeat (n_rand) gen_vec(1);
        test_name = "mixed";
        repeat (n_rand) gen_vec(2);

        test_name = "range_edge";
        repeat (n_edge) gen_vec(3);
        repeat (3) gen_vec(4);
        repeat (3) gen_vec(5);

        // back to back mixed with gaps
        test_name = "stream";
        repeat (n_stream) begin
            gen_vec(2);
            idle(rand_int(4));
        end

        test_name = "reset_stream";
        repeat (n_stream / 2) gen_vec(2);
        reset_dut(4);
        // nothing may come out until new input
        idle(2 * `CONV_LAT);
        repeat (n_stream / 2) gen_vec(2);
        idle(1);

        while (exp_data_q.size() != 0) begin
            @(posedge clk_i);
        end
        idle(`CONV_LAT + 2);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/conv_fp_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_fp_chk import conv_pkg::*; (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     valid_i,
    input logic [`CONV_COORD_W-1:0] row_i,
    input logic [`CONV_COORD_W-1:0] col_i,
    input logic                     valid_o,
    input logic [`CONV_COORD_W-1:0] row_o,
    input logic [`CONV_COORD_W-1:0] col_o,
    input fp_word_t                 data_o
);

    // reset seen at the last CONV_LAT edges, bit 0 newest
    logic [`CONV_LAT-1:0] rst_hist = '0;
    // set once the first reset has been seen
    logic                 armed    = 1'b0;

    always_ff @(posedge clk_i) begin
        rst_hist <= {rst_hist[`CONV_LAT-2:0], rst_i};
        if (rst_i) begin
            armed <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // reset and latency

    a_rst_clears: assert property (@(posedge clk_i) (rst_hist[1:0] != '0) |-> !valid_o)
        else $error("valid_o high during reset or the cycle after");

    // only when no reset touched the whole pipeline
    a_latency: assert property (@(posedge clk_i)
        (armed && (rst_hist == '0)) |-> (valid_o == $past(valid_i, `CONV_LAT)))
        else $error("valid_o does not follow valid_i by the pipeline latency");

    //////////////////////////////////////////////////
    // tags and data

    a_tags: assert property (@(posedge clk_i) valid_o |->
        ((row_o == $past(row_i, `CONV_LAT)) && (col_o == $past(col_i, `CONV_LAT))))
        else $error("row or col tag out of line with its result");

    a_no_x: assert property (@(posedge clk_i) valid_o |-> !$isunknown(data_o))
        else $error("data_o has unknown bits while valid");

endmodule

bind conv_fp_top conv_fp_chk u_chk (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .row_i   (row_i),
    .col_i   (col_i),
    .valid_o (valid_o),
    .row_o   (row_o),
    .col_o   (col_o),
    .data_o  (data_o)
);

`default_nettype wire

/* src/conv_fp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_fp_top import conv_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic [`CONV_TAPS-1:0][`CONV_FP_W-1:0]  window_i,
    input  logic [`CONV_TAPS-1:0][`CONV_FP_W-1:0]  kernel_i,
    input  logic [`CONV_TAPS-1:0]                  kern_short_i,
    input  logic [`CONV_COORD_W-1:0]               row_i,
    input  logic [`CONV_COORD_W-1:0]               col_i,
    input  logic                                   valid_i,
    output fp_word_t                               data_o,
    output logic [`CONV_COORD_W-1:0]               row_o,
    output logic [`CONV_COORD_W-1:0]               col_o,
    output logic                                   valid_o
);

    fp_word_t   [`CONV_TAPS-1:0] win_q;
    kern_word_u [`CONV_TAPS-1:0] kern_q;
    logic       [`CONV_TAPS-1:0] short_q;
    logic [`CONV_COORD_W-1:0]    row_q;
    logic [`CONV_COORD_W-1:0]    col_q;
    logic                        valid_q;
    fp_word_t   [`CONV_TAPS-1:0] prod_w;
    logic                        prod_valid_w;
    // tag delay after the input register
    logic [`CONV_COORD_W-1:0]    row_dly_q [`CONV_LAT-1];
    logic [`CONV_COORD_W-1:0]    col_dly_q [`CONV_LAT-1];

    //////////////////////////////////////////////////
    // input register

    always_ff @(posedge clk_i) begin
        win_q   <= window_i;
        kern_q  <= kernel_i;
        short_q <= kern_short_i;
        row_q   <= row_i;
        col_q   <= col_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    //////////////////////////////////////////////////
    // multiply stage, then adder tree

    conv_tap_mult u_tap_mult (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .win_i        (win_q),
        .kern_i       (kern_q),
        .short_i      (short_q),
        .in_valid_i   (valid_q),
        .prod_o       (prod_w),
        .prod_valid_o (prod_valid_w)
    );

    conv_add_tree u_add_tree (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .prod_i      (prod_w),
        .in_valid_i  (prod_valid_w),
        .sum_o       (data_o),
        .sum_valid_o (valid_o)
    );

    //////////////////////////////////////////////////
    // row / col delay line

    // five stages, lines up with the tree output
    always_ff @(posedge clk_i) begin
        row_dly_q[0] <= row_q;
        col_dly_q[0] <= col_q;
        for (int s = 1; s < `CONV_LAT - 1; s++) begin
            row_dly_q[s] <= row_dly_q[s-1];
            col_dly_q[s] <= col_dly_q[s-1];
        end
    end

    assign row_o = row_dly_q[`CONV_LAT-2];
    assign col_o = col_dly_q[`CONV_LAT-2];

endmodule

`default_nettype wire

/* src/conv_add_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_add_tree import conv_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  fp_word_t [`CONV_TAPS-1:0]   prod_i,
    input  logic                        in_valid_i,
    output fp_word_t                    sum_o,
    output logic                        sum_valid_o
);

    fp_word_t [`CONV_TREE_IN-1:0] pad_w;

    // taps 9..15 are +0
    always_comb begin
        pad_w = '0;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            pad_w[t] = prod_i[t];
        end
    end

    //////////////////////////////////////////////////
    // four registered levels, 8 / 4 / 2 / 1 adders

    for (genvar l = 0; l < `CONV_TREE_LEVELS; l++) begin : g_lvl
        localparam int n_out = `CONV_TREE_IN >> (l + 1);

        fp_word_t [2*n_out-1:0] in_w;
        fp_word_t [n_out-1:0]   sum_w;
        fp_word_t [n_out-1:0]   sum_q;
        logic                   vld_in_w;
        logic                   vld_q;

        // level input is the padded products or the previous level
        if (l == 0) begin : g_first
            assign in_w     = pad_w;
            assign vld_in_w = in_valid_i;
        end else begin : g_next
            assign in_w     = g_lvl[l-1].sum_q;
            assign vld_in_w = g_lvl[l-1].vld_q;
        end

        // neighbours in index order, 0+1 then 2+3
        for (genvar k = 0; k < n_out; k++) begin : g_add
            fp_add u_add (
                .a_i (in_w[2*k]),
                .b_i (in_w[2*k+1]),
                .s_o (sum_w[k])
            );
        end

        always_ff @(posedge clk_i) begin
            sum_q <= sum_w;
        end

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                vld_q <= 1'b0;
            end else begin
                vld_q <= vld_in_w;
            end
        end
    end

    // last level has a single node
    assign sum_o       = g_lvl[`CONV_TREE_LEVELS-1].sum_q[0];
    assign sum_valid_o = g_lvl[`CONV_TREE_LEVELS-1].vld_q;

endmodule

`default_nettype wire

/* src/conv_tap_mult.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_tap_mult import conv_pkg::*; (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  fp_word_t   [`CONV_TAPS-1:0]        win_i,
    input  kern_word_u [`CONV_TAPS-1:0]        kern_i,
    input  logic       [`CONV_TAPS-1:0]        short_i,
    input  logic                               in_valid_i,
    output fp_word_t   [`CONV_TAPS-1:0]        prod_o,
    output logic                               prod_valid_o
);

    fp_word_t [`CONV_TAPS-1:0] mul_w;
    fp_word_t [`CONV_TAPS-1:0] prod_w;
    logic     [`CONV_TAPS-1:0] zero_w;
    logic     [`CONV_TAPS-1:0] neg_w;

    //////////////////////////////////////////////////
    // per tap decode and multiply

    for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
        // opt view only when the shortcut flag is set
        assign zero_w[t] = short_i[t] && (kern_i[t].opt.cls == cls_zero);
        // unused class code 3 falls back to a positive scale
        assign neg_w[t]  = (kern_i[t].opt.cls == cls_neg_pow2);

        fp_mul u_mul (
            .a_i       (win_i[t]),
            .b_i       (kern_i[t].fp),
            .pow2_en_i (short_i[t]),
            .neg_i     (neg_w[t]),
            .shift_i   (kern_i[t].opt.shift),
            .p_o       (mul_w[t])
        );

        // zero class ignores the multiplier output
        assign prod_w[t] = zero_w[t] ? '0 : mul_w[t];
    end

    //////////////////////////////////////////////////
    // product register

    always_ff @(posedge clk_i) begin
        prod_o <= prod_w;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prod_valid_o <= 1'b0;
        end else begin
            prod_valid_o <= in_valid_i;
        end
    end

endmodule

`default_nettype wire

/* src/fp_add.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module fp_add import conv_pkg::*; (
    input  fp_word_t a_i,
    input  fp_word_t b_i,
    output fp_word_t s_o
);

    localparam int ew  = `CONV_EXP_W + 3;
    localparam int sw  = `CONV_FRAC_W + 1;
    localparam int lzw = $clog2(sw);
    localparam logic signed [ew-1:0] exp_sat = ew'((1 << `CONV_EXP_W) - 2);

    logic                    a_zero;
    logic                    b_zero;
    logic                    a_big;
    fp_word_t                op_hi;
    fp_word_t                op_lo;
    logic [`CONV_EXP_W-1:0]  exp_diff;
    logic [sw-1:0]           sig_hi;
    logic [sw-1:0]           sig_lo;
    logic [sw:0]             sig_sum;
    logic [lzw-1:0]          lz;
    logic [sw-1:0]           sig_norm;
    logic signed [ew-1:0]    res_exp;
    logic [`CONV_FRAC_W-1:0] res_frac;

    assign a_zero = (a_i.exp == '0);
    assign b_zero = (b_i.exp == '0);

    //////////////////////////////////////////////////
    // order by magnitude and align

    // exp sits above frac so one compare covers both
    assign a_big = ({a_i.exp, a_i.frac} >= {b_i.exp, b_i.frac});
    assign op_hi = a_big ? a_i : b_i;
    assign op_lo = a_big ? b_i : a_i;

    assign exp_diff = op_hi.exp - op_lo.exp;
    assign sig_hi   = {1'b1, op_hi.frac};
    // bits shifted out are dropped
    assign sig_lo   = {1'b1, op_lo.frac} >> exp_diff;

    // larger magnitude first, so the difference never goes negative
    assign sig_sum = (op_hi.sign == op_lo.sign) ? ({1'b0, sig_hi} + {1'b0, sig_lo})
                                                : ({1'b0, sig_hi} - {1'b0, sig_lo});

    //////////////////////////////////////////////////
    // normalize

    always_comb begin
        // highest set bit wins
        lz = '0;
        for (int i = 0; i < sw; i++) begin
            if (sig_sum[i]) begin
                lz = lzw'(sw - 1 - i);
            end
        end
        sig_norm = sig_sum[sw-1:0] << lz;
        if (sig_sum[sw]) begin
            // carry out, one step right
            res_frac = sig_sum[sw-1:1];
            res_exp  = $signed({3'b000, op_hi.exp}) + ew'(1);
        end else begin
            res_frac = sig_norm[sw-2:0];
            res_exp  = $signed({3'b000, op_hi.exp}) - $signed({{(ew-lzw){1'b0}}, lz});
        end
    end

    // zero operands bypass the datapath
    always_comb begin
        if (a_zero && b_zero) begin
            // +0 plus -0 gives +0
            s_o = '0;
        end else if (a_zero) begin
            s_o = b_i;
        end else if (b_zero) begin
            s_o = a_i;
        end else if ((sig_sum == '0) || res_exp[ew-1] || (res_exp == '0)) begin
            // exact cancellation or underflow
            s_o = '0;
        end else if (res_exp > exp_sat) begin
            s_o.sign = op_hi.sign;
            s_o.exp  = exp_sat[`CONV_EXP_W-1:0];
            s_o.frac = '1;
        end else begin
            s_o.sign = op_hi.sign;
            s_o.exp  = res_exp[`CONV_EXP_W-1:0];
            s_o.frac = res_frac;
        end
    end

endmodule

`default_nettype wire

/* src/fp_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module fp_mul import conv_pkg::*; (
    input  fp_word_t                      a_i,
    input  fp_word_t                      b_i,
    input  logic                          pow2_en_i,
    input  logic                          neg_i,
    input  logic signed [`CONV_EXP_W-1:0] shift_i,
    output fp_word_t                      p_o
);

    // exponent math needs headroom for sign and overflow
    localparam int ew = `CONV_EXP_W + 3;
    localparam int sw = `CONV_FRAC_W + 1;
    localparam logic signed [ew-1:0] bias_s  = ew'(`CONV_BIAS);
    localparam logic signed [ew-1:0] exp_sat = ew'((1 << `CONV_EXP_W) - 2);

    logic                    a_zero;
    logic                    b_zero;
    logic [sw-1:0]           sig_a;
    logic [sw-1:0]           sig_b;
    logic [2*sw-1:0]         sig_p;
    logic [`CONV_FRAC_W-1:0] mul_frac;
    logic signed [ew-1:0]    mul_exp;
    logic                    res_sign;
    logic signed [ew-1:0]    res_exp;
    logic [`CONV_FRAC_W-1:0] res_frac;
    logic                    res_zero;

    // subnormals flush to zero
    assign a_zero = (a_i.exp == '0);
    assign b_zero = (b_i.exp == '0);

    //////////////////////////////////////////////////
    // full multiply path

    assign sig_a = {1'b1, a_i.frac};
    assign sig_b = {1'b1, b_i.frac};
    assign sig_p = sig_a * sig_b;

    // product lies in [1,4), at most one bit of normalization
    always_comb begin
        if (sig_p[2*sw-1]) begin
            mul_frac = sig_p[2*sw-2 -: `CONV_FRAC_W];
        end else begin
            mul_frac = sig_p[2*sw-3 -: `CONV_FRAC_W];
        end
        mul_exp = $signed({3'b000, a_i.exp}) + $signed({3'b000, b_i.exp}) - bias_s
                + $signed({{(ew-1){1'b0}}, sig_p[2*sw-1]});
    end

    //////////////////////////////////////////////////
    // path select

    always_comb begin
        if (pow2_en_i) begin
            // scale by 2^shift, fraction untouched
            res_sign = a_i.sign ^ neg_i;
            res_exp  = $signed({3'b000, a_i.exp}) + ew'(shift_i);
            res_frac = a_i.frac;
            res_zero = a_zero;
        end else begin
            res_sign = a_i.sign ^ b_i.sign;
            res_exp  = mul_exp;
            res_frac = mul_frac;
            res_zero = a_zero | b_zero;
        end
    end

    // underflow to +0, overflow saturates with sign kept
    always_comb begin
        if (res_zero || res_exp[ew-1] || (res_exp == '0)) begin
            p_o = '0;
        end else if (res_exp > exp_sat) begin
            p_o.sign = res_sign;
            p_o.exp  = exp_sat[`CONV_EXP_W-1:0];
            p_o.frac = '1;
        end else begin
            p_o.sign = res_sign;
            p_o.exp  = res_exp[`CONV_EXP_W-1:0];
            p_o.frac = res_frac;
        end
    end

endmodule

`default_nettype wire

/* src/conv_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

    // one half-width float word
    typedef struct packed {
        logic                    sign;
        logic [`CONV_EXP_W-1:0]  exp;
        logic [`CONV_FRAC_W-1:0] frac;
    } fp_word_t;

    // shortcut classes carried in the opt view
    typedef enum logic [1:0] {
        cls_zero     = 2'd0,
        cls_pos_pow2 = 2'd1,
        cls_neg_pow2 = 2'd2
    } tap_cls_e;

    // opt view layout, class on top and shift at the bottom
    typedef struct packed {
        tap_cls_e                            cls;
        logic [`CONV_FP_W-`CONV_EXP_W-3:0]   rsvd;
        logic signed [`CONV_EXP_W-1:0]       shift;
    } kern_opt_t;

    // kernel word, decoded per tap by the shortcut flag
    typedef union packed {
        fp_word_t  fp;
        kern_opt_t opt;
    } kern_word_u;

endpackage

`default_nettype wire

/* include/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// half-width float fields
`define CONV_EXP_W       5
`define CONV_FRAC_W      10
`define CONV_FP_W        16
`define CONV_BIAS        15

// 3x3 window, tree padded up to a power of two
`define CONV_TAPS        9
`define CONV_TREE_IN     16
`define CONV_TREE_LEVELS 4

// row / column tag width
`define CONV_COORD_W     16

// input reg + multiply stage + four adder levels
`define CONV_LAT         6

`endif
